// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cave_input
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== cave_input_checker.sv ====
// Checker for the arcade input front end that models and compares the DUT outputs each cycle
`timescale 1ns/1ps

module cave_input_checker (
  input  logic                             clk_sys,
  input  logic                             RESET,
  input  logic                             pll_locked,
  input  cave_input_pkg::ps2_key_t         ps2_key,
  input  logic [31:0]                      joystick_0,
  input  logic [31:0]                      joystick_1,
  input  logic [31:0]                      status,
  input  logic [1:0]                       buttons,
  input  logic                             forced_scandoubler,
  input  cave_input_pkg::player_controls_t [cave_input_pkg::PLAYER_COUNT-1:0] players,
  input  cave_input_pkg::options_t         options,
  input  logic                             pll_reset,
  input  logic                             cpu_reset,
  output int                               error_count
);

  // Model state updated on rising edges
  logic [cave_input_pkg::CONTROL_BITS-1:0] key_model [cave_input_pkg::PLAYER_COUNT];
  logic toggle_seen = 1'b0;
  logic lock_seen = 1'b0;
  int   lock_left = 0;
  int   release_left = cave_input_pkg::RESET_SYNC_STAGES;
  int   cycle = 0;
  int   errors = 0;
  // Pending key events as due cycle and {pressed, code}
  int         ev_due [$];
  logic [8:0] ev_data [$];
  logic [cave_input_pkg::CONTROL_BITS-1:0] expected_keys;
  logic raw_reset;

  assign error_count = errors;
  assign raw_reset = RESET | ~pll_locked | status[0] | buttons[1];

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  function automatic cave_input_pkg::options_t expected_options(input logic [31:0] s,
                                                                input logic fsd);
    cave_input_pkg::options_t o;
    logic [2:0] effect;
    effect = s[7:5];
    o = '0;
    o.rotate = s[3];
    o.flip = s[4];
    case (s[2:1])
      2'd0: begin
        // 4:3 original, 3:4 rotated
        o.aspect_arx = s[3] ? 12'd3 : 12'd4;
        o.aspect_ary = s[3] ? 12'd4 : 12'd3;
      end
      default: begin
        o.aspect_arx = 12'(s[2:1]) - 12'd1;
        o.aspect_ary = 12'd0;
      end
    endcase
    o.scanlines = (effect == 3'd0) ? 2'd0 : effect[1:0] - 2'd1;
    o.hq2x = (effect == 3'd1);
    o.scandoubler = (effect != 3'd0) | fsd;
    o.compatibility = s[8];
    // Debug bits are disables in the menu word
    o.layer_enable = ~s[13:10];
    o.row_scroll_enable = ~s[14];
    o.row_select_enable = ~s[15];
    o.sprite_fb_enable = ~s[16];
    o.system_fb_enable = ~s[17];
    o.game_index = s[21:18];
    o.offset_x = s[27:24];
    o.offset_y = s[31:28];
    o.reset_request = s[0];
    return o;
  endfunction

  // Every map slot holding the code takes the pressed state
  task automatic apply_key(input logic [8:0] ev);
    for (int p = 0; p < cave_input_pkg::PLAYER_COUNT; p++) begin
      for (int i = 0; i < cave_input_pkg::CONTROL_BITS; i++) begin
        if (cave_input_pkg::KEY_MAPS[p][i] == ev[7:0] &&
            cave_input_pkg::KEY_MAPS[p][i] != cave_input_pkg::KEY_NONE) begin
          key_model[p][i] = ev[8];
        end
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("MISMATCH %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    errors++;
  endtask

  ////////////////////////////////////////
  // Model update on rising edges
  ////////////////////////////////////////

  always @(posedge clk_sys) begin
    cycle++;
    if (RESET) begin
      for (int p = 0; p < cave_input_pkg::PLAYER_COUNT; p++) begin
        key_model[p] = '0;
      end
      toggle_seen = 1'b0;
      lock_seen = 1'b0;
      lock_left = 0;
      ev_due.delete();
      ev_data.delete();
    end else begin
      // Events land two edges after the toggle is seen
      while (ev_due.size() > 0 && ev_due[0] == cycle) begin
        apply_key(ev_data.pop_front());
        void'(ev_due.pop_front());
      end
      if (ps2_key.toggle != toggle_seen) begin
        ev_due.push_back(cycle + 2);
        ev_data.push_back({ps2_key.pressed, ps2_key.code});
      end
      toggle_seen = ps2_key.toggle;
      // Lock loss restarts the full pulse
      if (lock_seen && !pll_locked) begin
        lock_left = cave_input_pkg::LOCK_RESET_CYCLES;
      end else if (lock_left > 0) begin
        lock_left--;
      end
      lock_seen = pll_locked;
    end
    // CPU reset release count
    if (raw_reset) begin
      release_left = cave_input_pkg::RESET_SYNC_STAGES;
    end else if (release_left > 0) begin
      release_left--;
    end
  end

  ////////////////////////////////////////
  // Compare on falling edges
  ////////////////////////////////////////

  always @(negedge clk_sys) begin
    // No model state before the first rising edge
    if (cycle > 0) begin
      for (int p = 0; p < cave_input_pkg::PLAYER_COUNT; p++) begin
        expected_keys = key_model[p] | ((p == 0) ? joystick_0[11:0] : joystick_1[11:0]);
        if (players[p] !== expected_keys) begin
          report_mismatch($sformatf("players[%0d]", p), 64'(expected_keys), 64'(players[p]));
        end
      end
      if (options !== expected_options(status, forced_scandoubler)) begin
        report_mismatch("options", 64'(expected_options(status, forced_scandoubler)),
                        64'(options));
      end
      if (pll_reset !== (lock_left != 0)) begin
        report_mismatch("pll_reset", 64'(lock_left != 0), 64'(pll_reset));
      end
      // Asserts at once and releases by count
      if (cpu_reset !== (raw_reset || release_left != 0)) begin
        report_mismatch("cpu_reset", 64'(raw_reset || release_left != 0), 64'(cpu_reset));
      end
    end
  end

endmodule

// ==== cave_input_pkg.sv ====
// Cave input front end shared constants, key maps and packed records
package cave_input_pkg;

  ////////////////////////////////////////
  // Sizes and timing
  ////////////////////////////////////////

  localparam int PLAYER_COUNT = 2;
  localparam int CONTROL_BITS = 12;
  // PLL reset pulse length after lock loss
  localparam int LOCK_RESET_CYCLES = 256;
  localparam int RESET_SYNC_STAGES = 2;

  // Empty key map slot
  localparam logic [7:0] KEY_NONE = 8'h00;

  ////////////////////////////////////////
  // Records
  ////////////////////////////////////////

  // Host keyboard word, toggle flips once per event
  typedef struct packed {
    logic       toggle;
    logic       pressed;
    logic       extended;
    logic [7:0] code;
  } ps2_key_t;

  typedef struct packed {
    logic       pressed;
    logic [7:0] code;
  } key_event_t;

  // Joystick bit order, right is bit 0
  typedef struct packed {
    logic       service;
    logic       pause;
    logic       coin;
    logic       start;
    logic [3:0] buttons;
    logic       up;
    logic       down;
    logic       left;
    logic       right;
  } player_controls_t;

  // One scan code per control bit
  typedef logic [CONTROL_BITS-1:0][7:0] key_map_t;

  // Listed from service down to right
  localparam key_map_t [PLAYER_COUNT-1:0] KEY_MAPS = {
    // Player 2: 0, none, 6, 2, W Q S A, R F D G
    {8'h45, KEY_NONE, 8'h36, 8'h1E, 8'h1D, 8'h15, 8'h1B, 8'h1C,
     8'h2D, 8'h2B, 8'h23, 8'h34},
    // Player 1: 9, P, 5, 1, shift space alt ctrl, arrows
    {8'h46, 8'h4D, 8'h2E, 8'h16, 8'h12, 8'h29, 8'h11, 8'h14,
     8'h75, 8'h72, 8'h6B, 8'h74}
  };

  // Decoded menu options
  typedef struct packed {
    logic [11:0] aspect_arx;
    logic [11:0] aspect_ary;
    logic [1:0]  scanlines;
    logic        scandoubler;
    logic        hq2x;
    logic        rotate;
    logic        flip;
    logic        compatibility;
    // Bit 0 sprites, bits 3:1 tile layers 2..0
    logic [3:0]  layer_enable;
    logic        row_scroll_enable;
    logic        row_select_enable;
    logic        sprite_fb_enable;
    logic        system_fb_enable;
    logic [3:0]  game_index;
    logic [3:0]  offset_x;
    logic [3:0]  offset_y;
    logic        reset_request;
  } options_t;

endpackage

// ==== cave_input_top.sv ====
// Arcade front end input and control top with key decode, options and resets
`timescale 1ns/1ps

module cave_input_top (
  input  logic                             clk_sys,
  input  logic                             RESET,
  input  logic                             pll_locked,
  input  cave_input_pkg::ps2_key_t         ps2_key,
  input  logic [31:0]                      joystick_0,
  input  logic [31:0]                      joystick_1,
  input  logic [31:0]                      status,
  input  logic [1:0]                       buttons,
  input  logic                             forced_scandoubler,
  output cave_input_pkg::player_controls_t [cave_input_pkg::PLAYER_COUNT-1:0] players,
  output cave_input_pkg::options_t         options,
  output logic                             pll_reset,
  output logic                             cpu_reset
);

  ////////////////////////////////////////
  // Keyboard and joysticks
  ////////////////////////////////////////

  cave_input_pkg::key_event_t key_event;
  logic                       key_strobe;

  // Joystick words indexed by player
  logic [cave_input_pkg::PLAYER_COUNT-1:0][31:0] joysticks;
  assign joysticks = {joystick_1, joystick_0};

  ps2_event_decoder ps2_event_decoder_i (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .ps2_key   (ps2_key),
    .key_event (key_event),
    .key_strobe(key_strobe)
  );

  // Same event stream to every player
  for (genvar g = 0; g < cave_input_pkg::PLAYER_COUNT; g++) begin : g_player
    player_key_latch #(
      .player_index(g)
    ) player_key_latch_i (
      .clk_sys   (clk_sys),
      .RESET     (RESET),
      .key_event (key_event),
      .key_strobe(key_strobe),
      .joystick  (joysticks[g][cave_input_pkg::CONTROL_BITS-1:0]),
      .controls  (players[g])
    );
  end

  ////////////////////////////////////////
  // Options and resets
  ////////////////////////////////////////

  menu_status_decode menu_status_decode_i (
    .status            (status),
    .forced_scandoubler(forced_scandoubler),
    .options           (options)
  );

  lock_loss_reset lock_loss_reset_i (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .pll_locked(pll_locked),
    .pll_reset (pll_reset)
  );

  // Board reset, lost lock, menu reset or user button
  logic cpu_reset_raw;
  assign cpu_reset_raw = RESET | ~pll_locked | options.reset_request | buttons[1];

  reset_sync reset_sync_i (
    .clk_sys   (clk_sys),
    .raw_reset (cpu_reset_raw),
    .sync_reset(cpu_reset)
  );

endmodule

// ==== lock_loss_reset.sv ====
// PLL lock-loss detector stretching a fixed-length PLL reset pulse
`timescale 1ns/1ps

module lock_loss_reset (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic pll_reset
);

  // Previous lock sample
  logic lock_last;
  // Remaining pulse cycles after the first
  logic [$clog2(cave_input_pkg::LOCK_RESET_CYCLES)-1:0] count;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      lock_last <= 1'b0;
      count     <= '0;
      pll_reset <= 1'b0;
    end else begin
      lock_last <= pll_locked;
      if (lock_last && !pll_locked) begin
        // Lock lost, also restarts a running pulse
        count     <= ($bits(count))'(cave_input_pkg::LOCK_RESET_CYCLES - 1);
        pll_reset <= 1'b1;
      end else if (count != '0) begin
        count <= count - 1'b1;
      end else begin
        // Counter ran out
        pll_reset <= 1'b0;
      end
    end
  end

endmodule

// ==== menu_status_decode.sv ====
// Menu status decoder producing the packed options record
`timescale 1ns/1ps

module menu_status_decode (
  input  logic [31:0]               status,
  input  logic                      forced_scandoubler,
  output cave_input_pkg::options_t  options
);

  // Aspect ratio field and scandoubler effect
  logic [1:0] aspect;
  logic [2:0] fx;

  assign aspect = status[2:1];
  assign fx     = status[7:5];

  always_comb begin
    options = '0;

    ////////////////////////////////////////
    // Video
    ////////////////////////////////////////

    options.rotate = status[3];
    options.flip   = status[4];
    if (aspect == 2'd0) begin
      // Original 4:3, swapped when rotated
      options.aspect_arx = status[3] ? 12'd3 : 12'd4;
      options.aspect_ary = status[3] ? 12'd4 : 12'd3;
    end else begin
      options.aspect_arx = 12'(aspect - 2'd1);
      options.aspect_ary = 12'd0;
    end
    // Effect 1 is HQ2x, above that CRT scanlines
    options.scanlines     = (fx != 3'd0) ? 2'(fx - 3'd1) : 2'd0;
    options.hq2x          = (fx == 3'd1);
    options.scandoubler   = (fx != 3'd0) || forced_scandoubler;
    options.compatibility = status[8];

    ////////////////////////////////////////
    // Debug enables, menu bits are disables
    ////////////////////////////////////////

    options.layer_enable      = ~status[13:10];
    options.row_scroll_enable = ~status[14];
    options.row_select_enable = ~status[15];
    options.sprite_fb_enable  = ~status[16];
    options.system_fb_enable  = ~status[17];

    // Game select and CRT offsets
    options.game_index    = status[21:18];
    options.offset_x      = status[27:24];
    options.offset_y      = status[31:28];
    options.reset_request = status[0];
  end

endmodule

// ==== player_key_latch.sv ====
// Per-player key state latch merged with that player's joystick bits
`timescale 1ns/1ps

module player_key_latch #(
  parameter int player_index = 0
) (
  input  logic                                    clk_sys,
  input  logic                                    RESET,
  input  cave_input_pkg::key_event_t              key_event,
  input  logic                                    key_strobe,
  input  logic [cave_input_pkg::CONTROL_BITS-1:0] joystick,
  output cave_input_pkg::player_controls_t        controls
);

  ////////////////////////////////////////
  // Key map lookup
  ////////////////////////////////////////

  // Fixed per instance
  cave_input_pkg::key_map_t key_map;
  assign key_map = cave_input_pkg::KEY_MAPS[player_index];

  // One match line per control bit
  logic [cave_input_pkg::CONTROL_BITS-1:0] hit;

  always_comb begin
    for (int i = 0; i < cave_input_pkg::CONTROL_BITS; i++) begin
      // Empty slots never match, even for code 00
      hit[i] = (key_map[i] != cave_input_pkg::KEY_NONE) &&
               (key_map[i] == key_event.code);
    end
  end

  ////////////////////////////////////////
  // Latched keys
  ////////////////////////////////////////

  logic [cave_input_pkg::CONTROL_BITS-1:0] keys;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      keys <= '0;
    end else if (key_strobe) begin
      for (int i = 0; i < cave_input_pkg::CONTROL_BITS; i++) begin
        if (hit[i]) begin
          // Press sets, release clears
          keys[i] <= key_event.pressed;
        end
      end
    end
  end

  // Joystick merges in without delay
  assign controls = cave_input_pkg::player_controls_t'(keys | joystick);

endmodule

// ==== ps2_event_decoder.sv ====
// PS/2 event decoder turning the host toggle word into a one-cycle key event strobe
`timescale 1ns/1ps

module ps2_event_decoder (
  input  logic                      clk_sys,
  input  logic                      RESET,
  input  cave_input_pkg::ps2_key_t  ps2_key,
  output cave_input_pkg::key_event_t key_event,
  output logic                      key_strobe
);

  // First stage toggle sample and the one before it
  logic toggle_sample;
  logic toggle_last;
  // Payload sampled alongside the toggle
  cave_input_pkg::key_event_t sample_event;

  // Toggle tracking and strobe
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_sample <= 1'b0;
      toggle_last   <= 1'b0;
      key_strobe    <= 1'b0;
    end else begin
      toggle_sample <= ps2_key.toggle;
      toggle_last   <= toggle_sample;
      // Any flip is a new event, held for one cycle only
      key_strobe    <= toggle_sample ^ toggle_last;
    end
  end

  // Payload path, follows the toggle stages
  always_ff @(posedge clk_sys) begin
    sample_event.pressed <= ps2_key.pressed;
    sample_event.code    <= ps2_key.code;
    key_event            <= sample_event;
  end

endmodule

// ==== reset_sync.sv ====
// Reset synchronizer with asynchronous assert and clk_sys aligned release
`timescale 1ns/1ps

module reset_sync (
  input  logic clk_sys,
  input  logic raw_reset,
  output logic sync_reset
);

  // Preset chain, zeros shift in from bit 0
  logic [cave_input_pkg::RESET_SYNC_STAGES-1:0] stages;

  always_ff @(posedge clk_sys or posedge raw_reset) begin
    if (raw_reset) begin
      stages <= '1;
    end else begin
      stages <= {stages[cave_input_pkg::RESET_SYNC_STAGES-2:0], 1'b0};
    end
  end

  // Last stage drives the reset
  assign sync_reset = stages[cave_input_pkg::RESET_SYNC_STAGES-1];

endmodule

// ==== tb_cave_input.sv ====
// Testbench top for the arcade input front end with seeded random host stimulus
`timescale 1ns/1ps

module tb_cave_input;

  // Codes found in neither key map
  localparam logic [7:0] UNMAPPED_CODES [4] = '{8'h5A, 8'h76, 8'h0D, 8'h66};

  logic                             clk_sys;
  logic                             RESET;
  logic                             pll_locked;
  cave_input_pkg::ps2_key_t         ps2_key;
  logic [31:0]                      joystick_0;
  logic [31:0]                      joystick_1;
  logic [31:0]                      status;
  logic [1:0]                       buttons;
  logic                             forced_scandoubler;
  cave_input_pkg::player_controls_t [cave_input_pkg::PLAYER_COUNT-1:0] players;
  cave_input_pkg::options_t         options;
  logic                             pll_reset;
  logic                             cpu_reset;

  integer seed;
  int     lock_low;
  int     timeout_count;
  int     mismatch_count;

  cave_input_top dut_i (.*);

  cave_input_checker checker_i (.*, .error_count(mismatch_count));

  initial begin
    clk_sys = 1'b0;
    forever #20 clk_sys = ~clk_sys;
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk_sys);
      #1;
    end
  endtask

  task automatic random_cycle();
    logic [31:0] r1;
    logic [31:0] r2;
    @(posedge clk_sys);
    #1;
    r1 = $random(seed);
    r2 = $random(seed);
    // Key event, one in four cycles
    if (r1[3:2] == 2'd0) begin
      ps2_key.toggle = ~ps2_key.toggle;
      ps2_key.pressed = r1[9];
      ps2_key.extended = r1[10];
      if (r1[5:4] == 2'd0) begin
        ps2_key.code = UNMAPPED_CODES[r1[7:6]];
      end else begin
        ps2_key.code = cave_input_pkg::KEY_MAPS[r1[8]][r1[15:12] % 12];
      end
    end else if (r1[3:2] == 2'd1) begin
      // Payload noise, toggle held
      ps2_key.code = r1[23:16];
      ps2_key.pressed = r1[11];
    end
    // Short lock drops
    if (lock_low == 0 && r1[31:24] == 8'h00) begin
      lock_low = 1 + r1[21:20];
    end
    pll_locked = (lock_low == 0);
    if (lock_low > 0) begin
      lock_low--;
    end
    if (r2[3:0] == 4'd0) begin
      status = $random(seed);
      status[0] = (r2[7:4] == 4'd0);
      forced_scandoubler = r2[8];
    end
    buttons = (r2[15:10] == 6'd0) ? r2[17:16] : 2'b00;
    if (r2[20:18] == 3'd0) begin
      joystick_0 = $random(seed);
    end
    if (r2[23:21] == 3'd0) begin
      joystick_1 = $random(seed);
    end
  endtask

  task automatic drop_lock(input int cycles);
    @(posedge clk_sys);
    #1;
    pll_locked = 1'b0;
    idle_cycles(cycles);
    pll_locked = 1'b1;
  endtask

  ////////////////////////////////////////
  // Bounded waits
  ////////////////////////////////////////

  task automatic wait_for_pll_reset(input logic level, input int limit);
    int n;
    n = 0;
    while (pll_reset !== level && n < limit) begin
      @(negedge clk_sys);
      n++;
    end
    if (pll_reset !== level) begin
      $display("Timeout: pll_reset did not reach %0d within %0d cycles", level, limit);
      timeout_count++;
    end
  endtask

  task automatic wait_for_cpu_release(input int limit);
    int n;
    n = 0;
    while (cpu_reset !== 1'b0 && n < limit) begin
      @(negedge clk_sys);
      n++;
    end
    if (cpu_reset !== 1'b0) begin
      $display("Timeout: cpu_reset was not released within %0d cycles", limit);
      timeout_count++;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed = 95483;
    lock_low = 0;
    timeout_count = 0;
    RESET = 1'b1;
    pll_locked = 1'b1;
    ps2_key = '0;
    joystick_0 = '0;
    joystick_1 = '0;
    status = '0;
    buttons = '0;
    forced_scandoubler = 1'b0;
    repeat (2) @(posedge clk_sys);
    #1;
    RESET = 1'b0;
    wait_for_cpu_release(8);

    repeat (3000) random_cycle();

    // Lock loss, then a second loss inside the pulse
    status = '0;
    buttons = '0;
    pll_locked = 1'b1;
    wait_for_pll_reset(1'b0, 2 * cave_input_pkg::LOCK_RESET_CYCLES);
    drop_lock(1);
    wait_for_pll_reset(1'b1, 4);
    idle_cycles(100);
    drop_lock(2);
    wait_for_pll_reset(1'b0, 2 * cave_input_pkg::LOCK_RESET_CYCLES);
    wait_for_cpu_release(8);
    idle_cycles(4);

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
cave_input_pkg.sv
ps2_event_decoder.sv
player_key_latch.sv
lock_loss_reset.sv
reset_sync.sv
menu_status_decode.sv
cave_input_top.sv
cave_input_checker.sv
tb_cave_input.sv
